/* rtl/irq_gen_pkg.sv */
////////////////////////////////////////////////////////////
// Register map and widths of the APB side. Byte offsets are
// word aligned and only the listed offsets are decoded
////////////////////////////////////////////////////////////

`default_nettype none

package irq_gen_pkg;

  // APB bus widths
  typedef logic [7:0]  apb_addr_t;
  typedef logic [31:0] apb_data_t;

  // Delay counts and program counter
  typedef logic [15:0] cycles_t;
  typedef logic [31:0] pc_t;

  // Stimulus modes as stored in REG_MODE
  typedef enum logic [1:0] {
    STANDARD         = 2'd0,
    RANDOM           = 2'd1,
    PC_TRIG          = 2'd2,
    SOFTWARE_DEFINED = 2'd3
  } irq_mode_e;

  ////////////////////////////////////////////////////////////
  // Register offsets
  ////////////////////////////////////////////////////////////

  localparam apb_addr_t REG_MODE       = 8'h00;
  localparam apb_addr_t REG_MIN_CYCLES = 8'h04;
  localparam apb_addr_t REG_MAX_CYCLES = 8'h08;
  localparam apb_addr_t REG_MIN_ID     = 8'h0C;
  localparam apb_addr_t REG_MAX_ID     = 8'h10;
  localparam apb_addr_t REG_PC_TRIG    = 8'h14;
  localparam apb_addr_t REG_LINES      = 8'h18;
  // Status registers, writes are rejected
  localparam apb_addr_t REG_ACT_ID     = 8'h1C;
  localparam apb_addr_t REG_ACK_ID     = 8'h20;

  ////////////////////////////////////////////////////////////
  // Reset values
  ////////////////////////////////////////////////////////////

  // Upper delay bound after reset
  localparam cycles_t MAX_CYCLES_RST = 16'd16;

  // LFSR start value, must not be zero
  localparam logic [15:0] LFSR_SEED = 16'hACE1;

endpackage

`default_nettype wire

/* rtl/irq_line_pkg.sv */
////////////////////////////////////////////////////////////
// Interrupt line layout of the core. Ids outside 3, 7, 11
// and 16 to 31 have no physical line
////////////////////////////////////////////////////////////

`default_nettype none

package irq_line_pkg;

  localparam int unsigned NUM_LINES = 19;

  // Software view and physical view
  typedef logic [31:0]          irq_word_t;
  typedef logic [4:0]           irq_id_t;
  typedef logic [NUM_LINES-1:0] irq_lines_t;

  // Ids that reach the core
  localparam irq_id_t ID_SOFTWARE = 5'd3;
  localparam irq_id_t ID_TIMER    = 5'd7;
  localparam irq_id_t ID_EXTERNAL = 5'd11;
  localparam irq_id_t ID_FAST_LO  = 5'd16;
  localparam irq_id_t ID_FAST_HI  = 5'd31;

  // Software at the top, fast lines at the bottom
  function automatic irq_lines_t map_word_to_lines(irq_word_t word);
    return {word[ID_SOFTWARE], word[ID_TIMER], word[ID_EXTERNAL],
            word[ID_FAST_HI:ID_FAST_LO]};
  endfunction

  function automatic logic id_is_valid(irq_id_t id);
    return (id == ID_SOFTWARE) || (id == ID_TIMER) ||
           (id == ID_EXTERNAL) || (id >= ID_FAST_LO);
  endfunction

endpackage

`default_nettype wire

/* rtl/irq_gen_apb_regs.sv */
////////////////////////////////////////////////////////////
// APB slave without wait states. Unmapped offsets and writes
// to the status registers return pslverr and change nothing
////////////////////////////////////////////////////////////

`default_nettype none

module irq_gen_apb_regs (
  input  wire                        clk_i,
  input  wire                        rst_ni,
  // APB slave
  input  wire irq_gen_pkg::apb_addr_t paddr_i,
  input  wire                        psel_i,
  input  wire                        penable_i,
  input  wire                        pwrite_i,
  input  wire irq_gen_pkg::apb_data_t pwdata_i,
  output irq_gen_pkg::apb_data_t     prdata_o,
  output logic                       pready_o,
  output logic                       pslverr_o,
  // Status from the sources
  input  wire                        rnd_valid_i,
  input  wire irq_line_pkg::irq_id_t rnd_id_i,
  input  wire                        ack_we_i,
  input  wire irq_line_pkg::irq_id_t ack_id_i,
  // Configuration
  output irq_gen_pkg::irq_mode_e     mode_o,
  output irq_gen_pkg::cycles_t       min_cycles_o,
  output irq_gen_pkg::cycles_t       max_cycles_o,
  output irq_line_pkg::irq_id_t      min_id_o,
  output irq_line_pkg::irq_id_t      max_id_o,
  output irq_gen_pkg::pc_t           pc_trig_o,
  output irq_line_pkg::irq_word_t    sd_word_o,
  output irq_line_pkg::irq_id_t      act_id_o
);

  import irq_gen_pkg::*;
  import irq_line_pkg::*;

  logic    access;
  logic    mapped;
  logic    read_only;
  logic    wr_en;
  logic    rnd_valid_q;
  irq_id_t ack_id_q;

  // Access cycle of a transfer
  assign access   = psel_i & penable_i;
  assign pready_o = 1'b1;

  ////////////////////////////////////////////////////////////
  // Address decode and read data
  ////////////////////////////////////////////////////////////

  always_comb begin
    mapped    = 1'b1;
    read_only = 1'b0;
    prdata_o  = '0;
    unique case (paddr_i)
      REG_MODE:       prdata_o = apb_data_t'(mode_o);
      REG_MIN_CYCLES: prdata_o = apb_data_t'(min_cycles_o);
      REG_MAX_CYCLES: prdata_o = apb_data_t'(max_cycles_o);
      REG_MIN_ID:     prdata_o = apb_data_t'(min_id_o);
      REG_MAX_ID:     prdata_o = apb_data_t'(max_id_o);
      REG_PC_TRIG:    prdata_o = pc_trig_o;
      REG_LINES:      prdata_o = sd_word_o;
      REG_ACT_ID: begin
        prdata_o  = apb_data_t'(act_id_o);
        read_only = 1'b1;
      end
      REG_ACK_ID: begin
        prdata_o  = apb_data_t'(ack_id_q);
        read_only = 1'b1;
      end
      default:        mapped = 1'b0;
    endcase
  end

  // Error only in the access cycle
  assign pslverr_o = access & (~mapped | (pwrite_i & read_only));
  assign wr_en     = access & pwrite_i & ~pslverr_o;

  ////////////////////////////////////////////////////////////
  // Configuration registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_o       <= STANDARD;
      min_cycles_o <= '0;
      max_cycles_o <= MAX_CYCLES_RST;
      min_id_o     <= '0;
      max_id_o     <= '0;
      pc_trig_o    <= '0;
      sd_word_o    <= '0;
    end else if (wr_en) begin
      if (paddr_i == REG_MODE)       mode_o       <= irq_mode_e'(pwdata_i[1:0]);
      // Ids keep only their low 5 bits
      if (paddr_i == REG_MIN_CYCLES) min_cycles_o <= pwdata_i[15:0];
      if (paddr_i == REG_MAX_CYCLES) max_cycles_o <= pwdata_i[15:0];
      if (paddr_i == REG_MIN_ID)     min_id_o     <= pwdata_i[4:0];
      if (paddr_i == REG_MAX_ID)     max_id_o     <= pwdata_i[4:0];
      if (paddr_i == REG_PC_TRIG)    pc_trig_o    <= pwdata_i;
      if (paddr_i == REG_LINES)      sd_word_o    <= pwdata_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Status registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rnd_valid_q <= 1'b0;
      act_id_o    <= '0;
      ack_id_q    <= '0;
    end else begin
      rnd_valid_q <= rnd_valid_i;
      // Chosen id is taken when the random source raises
      if (rnd_valid_i && !rnd_valid_q) begin
        act_id_o <= rnd_id_i;
      end
      if (ack_we_i) begin
        ack_id_q <= ack_id_i;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/irq_gen_random.sv */
////////////////////////////////////////////////////////////
// Random source with one line at a time. Search ends within
// 32 cycles and never ends when no id fits the bounds
////////////////////////////////////////////////////////////

`default_nettype none

module irq_gen_random (
  input  wire                         clk_i,
  input  wire                         rst_ni,
  input  wire irq_gen_pkg::irq_mode_e mode_i,
  input  wire irq_gen_pkg::cycles_t   min_cycles_i,
  input  wire irq_gen_pkg::cycles_t   max_cycles_i,
  input  wire irq_line_pkg::irq_id_t  min_id_i,
  input  wire irq_line_pkg::irq_id_t  max_id_i,
  input  wire                         clear_i,
  output logic                        rnd_valid_o,
  output irq_line_pkg::irq_id_t       rnd_id_o
);

  import irq_gen_pkg::*;
  import irq_line_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    SEARCH,
    DELAY,
    RAISED
  } rnd_state_e;

  rnd_state_e  state_q;
  logic [15:0] lfsr_q;
  logic        lfsr_fb;
  logic [4:0]  tries_q;
  cycles_t     cnt_q;
  irq_id_t     cand;
  logic        cand_ok;
  logic        scan_found;
  irq_id_t     scan_id;

  // Id usable by the core and inside the configured window
  function automatic logic id_in_bounds(irq_id_t id);
    return id_is_valid(id) && (id >= min_id_i) && (id <= max_id_i);
  endfunction

  // Taps 16 14 13 11 for a maximal length sequence
  assign lfsr_fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];

  assign cand    = lfsr_q[4:0];
  assign cand_ok = id_in_bounds(cand);

  // Fallback picks the lowest fitting id
  always_comb begin
    scan_found = 1'b0;
    scan_id    = '0;
    for (int i = 31; i >= 0; i--) begin
      if (id_in_bounds(irq_id_t'(i))) begin
        scan_found = 1'b1;
        scan_id    = irq_id_t'(i);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Chooser FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= IDLE;
      lfsr_q   <= LFSR_SEED;
      tries_q  <= '0;
      cnt_q    <= '0;
      rnd_id_o <= '0;
    end else begin
      lfsr_q <= {lfsr_q[14:0], lfsr_fb};
      if (mode_i != RANDOM) begin
        state_q <= IDLE;
      end else begin
        unique case (state_q)
          IDLE: begin
            state_q <= SEARCH;
            tries_q <= '0;
          end
          SEARCH: begin
            // 32nd miss falls through to the scan result
            if (cand_ok) begin
              state_q  <= DELAY;
              rnd_id_o <= cand;
              cnt_q    <= 16'd1;
            end else if (tries_q == 5'd31 && scan_found) begin
              state_q  <= DELAY;
              rnd_id_o <= scan_id;
              cnt_q    <= 16'd1;
            end else if (tries_q != 5'd31) begin
              tries_q <= tries_q + 5'd1;
            end
          end
          DELAY: begin
            // Count equals cycles spent here
            if (cnt_q >= max_cycles_i || (cnt_q >= min_cycles_i && lfsr_q[9])) begin
              state_q <= RAISED;
            end else begin
              cnt_q <= cnt_q + 16'd1;
            end
          end
          RAISED: begin
            if (clear_i) begin
              state_q <= SEARCH;
              tries_q <= '0;
            end
          end
          default: state_q <= IDLE;
        endcase
      end
    end
  end

  // Held until the driver clears it
  assign rnd_valid_o = (state_q == RAISED);

endmodule

`default_nettype wire

/* rtl/irq_gen_pc_trig.sv */
////////////////////////////////////////////////////////////
// PC trigger that fires once per arming. Entry into PC_TRIG
// mode or a clear arms it again
////////////////////////////////////////////////////////////

`default_nettype none

module irq_gen_pc_trig (
  input  wire                         clk_i,
  input  wire                         rst_ni,
  input  wire irq_gen_pkg::irq_mode_e mode_i,
  input  wire irq_gen_pkg::pc_t       pc_i,
  input  wire                         pc_valid_i,
  input  wire irq_gen_pkg::pc_t       pc_trig_i,
  input  wire                         clear_i,
  output logic                        trig_hit_o
);

  import irq_gen_pkg::*;

  irq_mode_e mode_q;
  logic      armed_q;
  logic      enter;
  logic      match;

  // First cycle in PC_TRIG mode
  assign enter = (mode_i == PC_TRIG) && (mode_q != PC_TRIG);

  // Valid fetch address equal to the trigger
  assign match = pc_valid_i && (pc_i == pc_trig_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_q     <= STANDARD;
      armed_q    <= 1'b0;
      trig_hit_o <= 1'b0;
    end else begin
      mode_q <= mode_i;
      if (mode_i != PC_TRIG) begin
        armed_q    <= 1'b0;
        trig_hit_o <= 1'b0;
      end else if (clear_i) begin
        // Acknowledge drops the hit and re-arms
        armed_q    <= 1'b1;
        trig_hit_o <= 1'b0;
      end else if (enter) begin
        armed_q <= 1'b1;
      end else if (armed_q && match) begin
        // Level stays up until the next clear
        armed_q    <= 1'b0;
        trig_hit_o <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/irq_gen_line_driver.sv */
////////////////////////////////////////////////////////////
// Line register and acknowledge path. An acknowledge clears
// lines only in RANDOM and PC_TRIG mode
////////////////////////////////////////////////////////////

`default_nettype none

module irq_gen_line_driver (
  input  wire                           clk_i,
  input  wire                           rst_ni,
  input  wire irq_gen_pkg::irq_mode_e   mode_i,
  input  wire irq_line_pkg::irq_word_t  sd_word_i,
  input  wire                           rnd_valid_i,
  input  wire irq_line_pkg::irq_id_t    rnd_id_i,
  input  wire                           trig_hit_i,
  input  wire                           irq_ack_i,
  input  wire irq_line_pkg::irq_id_t    irq_ack_id_i,
  output irq_line_pkg::irq_lines_t      irq_lines_o,
  output logic                          src_clear_o,
  output logic                          id_we_o,
  output irq_line_pkg::irq_id_t         ack_id_o
);

  import irq_gen_pkg::*;
  import irq_line_pkg::*;

  irq_mode_e  mode_q;
  irq_lines_t lines_d;
  logic       src_mode;
  logic       ack_hit;
  logic       mode_chg;

  // Modes whose lines come from a source with a clear
  assign src_mode = (mode_i == RANDOM) || (mode_i == PC_TRIG);
  assign ack_hit  = irq_ack_i && src_mode && (irq_lines_o != '0);
  assign mode_chg = (mode_i != mode_q);

  ////////////////////////////////////////////////////////////
  // Next line vector
  ////////////////////////////////////////////////////////////

  always_comb begin
    unique case (mode_i)
      RANDOM:  lines_d = rnd_valid_i ? map_word_to_lines(irq_word_t'(1) << rnd_id_i) : '0;
      PC_TRIG: lines_d = trig_hit_i ? map_word_to_lines(sd_word_i) : '0;
      SOFTWARE_DEFINED: lines_d = map_word_to_lines(sd_word_i);
      default: lines_d = '0;
    endcase
    // Source level is stale until the clear has landed
    if (src_mode && (ack_hit || src_clear_o)) begin
      lines_d = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_q      <= STANDARD;
      irq_lines_o <= '0;
      src_clear_o <= 1'b0;
      id_we_o     <= 1'b0;
      ack_id_o    <= '0;
    end else begin
      mode_q      <= mode_i;
      irq_lines_o <= lines_d;
      src_clear_o <= ack_hit | mode_chg;
      // Write enable toward the trace logger
      id_we_o     <= irq_ack_i;
      // Id follows the acknowledge pulse
      if (irq_ack_i) begin
        ack_id_o <= irq_ack_id_i;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/irq_gen_top.sv */
////////////////////////////////////////////////////////////
// Interrupt stimulus generator. pready is tied high and the
// core cannot stall the lines
////////////////////////////////////////////////////////////

`default_nettype none

module irq_gen_top (
  input  wire                         clk_i,
  input  wire                         rst_ni,
  // APB slave
  input  wire irq_gen_pkg::apb_addr_t paddr_i,
  input  wire                         psel_i,
  input  wire                         penable_i,
  input  wire                         pwrite_i,
  input  wire irq_gen_pkg::apb_data_t pwdata_i,
  output irq_gen_pkg::apb_data_t      prdata_o,
  output logic                        pready_o,
  output logic                        pslverr_o,
  // Core side
  input  wire irq_gen_pkg::pc_t       pc_i,
  input  wire                         pc_valid_i,
  input  wire                         irq_ack_i,
  input  wire irq_line_pkg::irq_id_t  irq_ack_id_i,
  output irq_line_pkg::irq_lines_t    irq_lines_o,
  output irq_line_pkg::irq_id_t       irq_act_id_o,
  output logic                        irq_id_we_o
);

  import irq_gen_pkg::*;
  import irq_line_pkg::*;

  // Configuration
  irq_mode_e mode;
  cycles_t   min_cycles;
  cycles_t   max_cycles;
  irq_id_t   min_id;
  irq_id_t   max_id;
  pc_t       pc_trig;
  irq_word_t sd_word;

  // Sources and status
  logic      rnd_valid;
  irq_id_t   rnd_id;
  logic      trig_hit;
  logic      src_clear;
  irq_id_t   ack_id;

  irq_gen_apb_regs u_regs (
    .clk_i, .rst_ni,
    .paddr_i, .psel_i, .penable_i, .pwrite_i, .pwdata_i,
    .prdata_o, .pready_o, .pslverr_o,
    .rnd_valid_i (rnd_valid),  .rnd_id_i (rnd_id),
    .ack_we_i    (irq_id_we_o), .ack_id_i (ack_id),
    .mode_o      (mode),
    .min_cycles_o(min_cycles), .max_cycles_o(max_cycles),
    .min_id_o    (min_id),     .max_id_o    (max_id),
    .pc_trig_o   (pc_trig),    .sd_word_o   (sd_word),
    .act_id_o    (irq_act_id_o)
  );

  irq_gen_random u_random (
    .clk_i, .rst_ni,
    .mode_i      (mode),
    .min_cycles_i(min_cycles), .max_cycles_i(max_cycles),
    .min_id_i    (min_id),     .max_id_i    (max_id),
    .clear_i     (src_clear),
    .rnd_valid_o (rnd_valid),  .rnd_id_o    (rnd_id)
  );

  irq_gen_pc_trig u_pc_trig (
    .clk_i, .rst_ni,
    .mode_i   (mode), .pc_i, .pc_valid_i,
    .pc_trig_i(pc_trig), .clear_i(src_clear),
    .trig_hit_o(trig_hit)
  );

  irq_gen_line_driver u_driver (
    .clk_i, .rst_ni,
    .mode_i     (mode),      .sd_word_i(sd_word),
    .rnd_valid_i(rnd_valid), .rnd_id_i (rnd_id),
    .trig_hit_i (trig_hit),
    .irq_ack_i, .irq_ack_id_i,
    .irq_lines_o,
    .src_clear_o(src_clear), .id_we_o(irq_id_we_o),
    .ack_id_o   (ack_id)
  );

endmodule

`default_nettype wire

/* verification/irq_gen_tb_tasks.svh */
////////////////////////////////////////////////////////////
// Tasks of the interrupt generator testbench, included in
// the testbench module. Inputs change on the falling edge
////////////////////////////////////////////////////////////

`ifndef IRQ_GEN_TB_TASKS_SVH
`define IRQ_GEN_TB_TASKS_SVH

////////////////////////////////////////////////////////////
// Reference model of the line layout
////////////////////////////////////////////////////////////

// Software, timer and external on top of the fast lines
function automatic irq_lines_t mapped_lines(input irq_word_t word);
  return {word[3], word[7], word[11], word[31:16]};
endfunction

function automatic logic core_has_id(input irq_id_t id);
  return (id == 5'd3) || (id == 5'd7) || (id == 5'd11) || (id >= 5'd16);
endfunction

// Id of a single raised line
function automatic irq_id_t line_id(input irq_lines_t lines);
  irq_id_t id;
  id = '0;
  for (int i = 0; i < 16; i++) begin
    if (lines[i]) id = irq_id_t'(16 + i);
  end
  if (lines[16]) id = 5'd11;
  if (lines[17]) id = 5'd7;
  if (lines[18]) id = 5'd3;
  return id;
endfunction

////////////////////////////////////////////////////////////
// Compare tasks
////////////////////////////////////////////////////////////

task automatic check_lines(input string name, input irq_lines_t got, input irq_lines_t exp);
  if (got !== exp) begin
    abort_run($sformatf("FAILED at %0d ns: %s = %h, expected %h", $time, name, got, exp));
  end
endtask

task automatic check_id(input string name, input irq_id_t got, input irq_id_t exp);
  if (got !== exp) begin
    abort_run($sformatf("FAILED at %0d ns: %s = %0d, expected %0d", $time, name, got, exp));
  end
endtask

task automatic check_data(input string name, input apb_data_t got, input apb_data_t exp);
  if (got !== exp) begin
    abort_run($sformatf("FAILED at %0d ns: %s = %h, expected %h", $time, name, got, exp));
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    abort_run($sformatf("FAILED at %0d ns: %s = %b, expected %b", $time, name, got, exp));
  end
endtask

////////////////////////////////////////////////////////////
// APB access
////////////////////////////////////////////////////////////

task automatic apb_access(input apb_addr_t addr, input logic wr, input apb_data_t wdata,
                          output apb_data_t rdata, output logic err);
  @(negedge clk_i);
  psel_i    = 1'b1;
  penable_i = 1'b0;
  pwrite_i  = wr;
  paddr_i   = addr;
  pwdata_i  = wdata;
  @(negedge clk_i);
  penable_i = 1'b1;
  // Sample in the middle of the access cycle
  #(CLK_PERIOD / 4);
  rdata = prdata_o;
  err   = pslverr_o;
  check_bit("pready_o", pready_o, 1'b1);
  @(negedge clk_i);
  psel_i      = 1'b0;
  penable_i   = 1'b0;
  pwrite_i    = 1'b0;
  write_cycle = cycle_cnt;
endtask

task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
  apb_data_t unused;
  apb_access(addr, 1'b1, data, unused, err);
endtask

task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
  apb_access(addr, 1'b0, '0, data, err);
endtask

// Accesses to mapped registers must not error
task automatic write_reg(input apb_addr_t addr, input apb_data_t data);
  logic err;
  apb_write(addr, data, err);
  check_bit("pslverr_o", err, 1'b0);
endtask

task automatic read_reg(input apb_addr_t addr, output apb_data_t data);
  logic err;
  apb_read(addr, data, err);
  check_bit("pslverr_o", err, 1'b0);
endtask

////////////////////////////////////////////////////////////
// Random mode helpers
////////////////////////////////////////////////////////////

task automatic wait_for_line(input int start, input int limit, output int waited);
  while (irq_lines_o == '0) begin
    if (cycle_cnt - start > limit) begin
      abort_run("Timeout while waiting for a random interrupt line");
    end else begin
      @(negedge clk_i);
    end
  end
  waited = cycle_cnt - start;
endtask

task automatic check_random_line(input irq_id_t lo, input irq_id_t hi);
  irq_id_t id;
  check_bit("single line raised", $countones(irq_lines_o) == 1, 1'b1);
  id = line_id(irq_lines_o);
  check_bit($sformatf("id %0d valid and in bounds", id),
            core_has_id(id) && (id >= lo) && (id <= hi), 1'b1);
  check_id("irq_act_id_o", irq_act_id_o, id);
endtask

// Configures the bounds and enters RANDOM, returns with a line raised
task automatic run_random(input irq_id_t lo, input irq_id_t hi,
                          input cycles_t cmin, input cycles_t cmax);
  int waited;
  write_reg(REG_MODE, STANDARD);
  write_reg(REG_MIN_ID, apb_data_t'(lo));
  write_reg(REG_MAX_ID, apb_data_t'(hi));
  write_reg(REG_MIN_CYCLES, apb_data_t'(cmin));
  write_reg(REG_MAX_CYCLES, apb_data_t'(cmax));
  write_reg(REG_MODE, RANDOM);
  wait_for_line(write_cycle, int'(cmax) + 40, waited);
  check_bit($sformatf("wait %0d >= %0d", waited, int'(cmin) + 2),
            waited >= int'(cmin) + 2, 1'b1);
  check_bit($sformatf("wait %0d <= %0d", waited, int'(cmax) + 34),
            waited <= int'(cmax) + 34, 1'b1);
  check_random_line(lo, hi);
endtask

////////////////////////////////////////////////////////////
// Directed tests
////////////////////////////////////////////////////////////

task automatic test_reset_regs();
  apb_addr_t addrs [7];
  apb_data_t masks [7];
  apb_data_t wdata;
  apb_data_t rdata;
  apb_data_t act_id;
  logic      err;
  addrs = '{REG_MIN_CYCLES, REG_MAX_CYCLES, REG_MIN_ID, REG_MAX_ID,
            REG_PC_TRIG, REG_LINES, REG_MODE};
  masks = '{32'h0000_ffff, 32'h0000_ffff, 32'h1f, 32'h1f, '1, '1, 32'h3};
  check_lines("irq_lines_o", irq_lines_o, '0);
  check_bit("irq_id_we_o", irq_id_we_o, 1'b0);
  read_reg(REG_MAX_CYCLES, rdata);
  check_data("prdata_o", rdata, 32'd16);
  for (int i = 0; i < 7; i++) begin
    wdata = $random(seed);
    write_reg(addrs[i], wdata);
    read_reg(addrs[i], rdata);
    check_data("prdata_o", rdata, wdata & masks[i]);
  end
  write_reg(REG_MODE, STANDARD);
  write_reg(REG_LINES, '0);
  // Status registers and holes in the map
  read_reg(REG_ACT_ID, act_id);
  // Inverted data so that an accepted write would show
  apb_write(REG_ACT_ID, ~act_id, err);
  check_bit("pslverr_o", err, 1'b1);
  read_reg(REG_ACT_ID, rdata);
  check_data("prdata_o", rdata, act_id);
  apb_write(REG_ACK_ID, $random(seed), err);
  check_bit("pslverr_o", err, 1'b1);
  apb_read(8'h24, rdata, err);
  check_bit("pslverr_o", err, 1'b1);
  apb_write(8'h40, $random(seed), err);
  check_bit("pslverr_o", err, 1'b1);
endtask

task automatic test_software_mode();
  apb_data_t word;
  apb_data_t prev;
  prev = '0;
  write_reg(REG_MODE, SOFTWARE_DEFINED);
  for (int i = 0; i < 8; i++) begin
    word = $random(seed);
    write_reg(REG_LINES, word);
    check_lines("irq_lines_o", irq_lines_o, mapped_lines(prev));
    @(negedge clk_i);
    check_lines("irq_lines_o", irq_lines_o, mapped_lines(word));
    prev = word;
  end
  write_reg(REG_MODE, STANDARD);
  // Old word still shows until the line register takes the mode
  check_lines("irq_lines_o", irq_lines_o, mapped_lines(prev));
  @(negedge clk_i);
  check_lines("irq_lines_o", irq_lines_o, '0);
endtask

task automatic test_random_mode();
  run_random(5'd16, 5'd31, 16'd2, 16'd10);
  run_random(5'd3, 5'd11, 16'd1, 16'd5);
  run_random(5'd20, 5'd20, 16'd4, 16'd4);
  run_random(5'd0, 5'd31, 16'd0, 16'd16);
  run_random(5'd7, 5'd8, 16'd6, 16'd12);
  write_reg(REG_MODE, STANDARD);
endtask

task automatic test_acknowledge();
  irq_id_t   ack_id;
  apb_data_t rdata;
  int        ack_cycle;
  int        waited;
  // Odd id never equals the reset value of REG_ACK_ID
  ack_id = irq_id_t'($random(seed)) | 5'd1;
  run_random(5'd16, 5'd31, 16'd1, 16'd8);
  irq_ack_i    = 1'b1;
  irq_ack_id_i = ack_id;
  @(negedge clk_i);
  ack_cycle = cycle_cnt;
  irq_ack_i = 1'b0;
  check_lines("irq_lines_o", irq_lines_o, '0);
  check_bit("irq_id_we_o", irq_id_we_o, 1'b1);
  @(negedge clk_i);
  check_lines("irq_lines_o", irq_lines_o, '0);
  check_bit("irq_id_we_o", irq_id_we_o, 1'b0);
  read_reg(REG_ACK_ID, rdata);
  check_data("prdata_o", rdata, apb_data_t'(ack_id));
  // Cleared source searches again
  wait_for_line(ack_cycle, 48, waited);
  check_random_line(5'd16, 5'd31);
  write_reg(REG_MODE, STANDARD);
endtask

// Match for one cycle, lines follow two cycles later
task automatic pc_match(input pc_t trig, input apb_data_t word);
  pc_i = trig;
  @(negedge clk_i);
  pc_i = trig + 32'd4;
  check_lines("irq_lines_o", irq_lines_o, '0);
  @(negedge clk_i);
  check_lines("irq_lines_o", irq_lines_o, mapped_lines(word));
endtask

task automatic test_pc_trigger();
  apb_data_t word;
  pc_t       trig;
  // Bit 16 keeps the trigger word visible on a fast line
  word = $random(seed) | 32'h0001_0000;
  trig = $random(seed);
  write_reg(REG_LINES, word);
  write_reg(REG_PC_TRIG, trig);
  write_reg(REG_MODE, PC_TRIG);
  pc_valid_i = 1'b1;
  pc_i       = trig + 32'd4;
  repeat (4) begin
    @(negedge clk_i);
    check_lines("irq_lines_o", irq_lines_o, '0);
  end
  pc_match(trig, word);
  // Disarmed until acknowledged
  pc_i = trig;
  @(negedge clk_i);
  pc_i = trig + 32'd4;
  repeat (3) begin
    @(negedge clk_i);
    check_lines("irq_lines_o", irq_lines_o, mapped_lines(word));
  end
  irq_ack_i    = 1'b1;
  irq_ack_id_i = 5'd16;
  @(negedge clk_i);
  irq_ack_i = 1'b0;
  check_lines("irq_lines_o", irq_lines_o, '0);
  repeat (2) @(negedge clk_i);
  pc_match(trig, word);
  pc_valid_i = 1'b0;
  write_reg(REG_MODE, STANDARD);
endtask

`endif

/* verification/irq_gen_tb.sv */
////////////////////////////////////////////////////////////
// Directed testbench, stops at the first mismatch. Random
// mode is checked against its bounds, not exact ids
////////////////////////////////////////////////////////////

`default_nettype none

module irq_gen_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import irq_gen_pkg::*;
  import irq_line_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 8;
  localparam int NUM_TESTS    = 5;
  // Search, largest delay in use, and APB traffic around it
  localparam int TEST_CYCLES  = 32 + 16 + 200;

  // DUT inputs
  logic      clk_i;
  logic      rst_ni;
  apb_addr_t paddr_i;
  logic      psel_i;
  logic      penable_i;
  logic      pwrite_i;
  apb_data_t pwdata_i;
  pc_t       pc_i;
  logic      pc_valid_i;
  logic      irq_ack_i;
  irq_id_t   irq_ack_id_i;

  // DUT outputs
  apb_data_t  prdata_o;
  logic       pready_o;
  logic       pslverr_o;
  irq_lines_t irq_lines_o;
  irq_id_t    irq_act_id_o;
  logic       irq_id_we_o;

  integer seed;
  int     cycle_cnt = 0;
  // Cycle count seen just after the last APB write edge
  int     write_cycle;

  irq_gen_top irq_gen_top_i (.*);

  // Prints the reason and ends the run
  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  `include "irq_gen_tb_tasks.svh"

  ////////////////////////////////////////////////////////////
  // Clock, cycle count and watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  initial begin
    #(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
    abort_run("Watchdog expired before the tests finished");
  end

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    seed         = 32'hf237;
    rst_ni       = 1'b0;
    paddr_i      = '0;
    psel_i       = 1'b0;
    penable_i    = 1'b0;
    pwrite_i     = 1'b0;
    pwdata_i     = '0;
    pc_i         = '0;
    pc_valid_i   = 1'b0;
    irq_ack_i    = 1'b0;
    irq_ack_id_i = '0;
    write_cycle  = 0;
    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_ni = 1'b1;
    test_reset_regs();
    test_software_mode();
    test_random_mode();
    test_acknowledge();
    test_pc_trigger();
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+verification
rtl/irq_gen_pkg.sv
rtl/irq_line_pkg.sv
rtl/irq_gen_apb_regs.sv
rtl/irq_gen_random.sv
rtl/irq_gen_pc_trig.sv
rtl/irq_gen_line_driver.sv
rtl/irq_gen_top.sv
verification/irq_gen_tb.sv

/* Makefile */
# Verilator build and run of the interrupt generator testbench
SIM := obj_dir/Virq_gen_tb

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): compile.f $(wildcard rtl/*.sv verification/*.sv verification/*.svh)
	verilator --binary --timing --timescale 1ns/1ps --top-module irq_gen_tb -f compile.f

# Exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir
